//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_pr_region
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(shell grep -v '^+' sim.f)
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): sim.f $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f sim.f

run: $(BIN)
	-$(BIN) | tee $(LOG)
	@if grep -q "Simulation failed" $(LOG); then exit 1; fi
	@grep -q "Simulation completed successfully" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- design/arith_persona.sv
// Basic arithmetic persona: two operands, an opcode and a result register.
// RESULT follows the operands with no extra delay seen by the next read.
`timescale 1ns/1ns

module arith_persona (
   input logic   pr_region_clk,
   input logic   rst_n,
   avmm_if.agent bus
);
   import pr_pkg::*;

   logic [DATA_W-1:0] reg_a;
   logic [DATA_W-1:0] reg_b;
   logic [DATA_W-1:0] reg_op;
   logic [DATA_W-1:0] a_nxt;
   logic [DATA_W-1:0] b_nxt;
   logic [DATA_W-1:0] op_nxt;
   logic [DATA_W-1:0] result;
   logic [DATA_W-1:0] rd_mux;

   function automatic logic [DATA_W-1:0] merge_bytes(
      input logic [DATA_W-1:0] old_word,
      input logic [DATA_W-1:0] new_word,
      input logic [BE_W-1:0]   be
   );
      logic [DATA_W-1:0] merged;
      merged = old_word;
      for (int i = 0; i < BE_W; i++) begin
         if (be[i]) begin
            merged[8*i +: 8] = new_word[8*i +: 8];
         end
      end
      return merged;
   endfunction

   function automatic logic [DATA_W-1:0] alu(
      input logic [DATA_W-1:0] a,
      input logic [DATA_W-1:0] b,
      input arith_op_e         op
   );
      logic [DATA_W-1:0] res;
      case (op)
         OP_ADD:  res = a + b;
         OP_SUB:  res = a - b;
         OP_MUL:  res = a * b;
         default: res = a & b;
      endcase
      return res;
   endfunction

   always_comb begin
      a_nxt  = reg_a;
      b_nxt  = reg_b;
      op_nxt = reg_op;
      if (bus.write) begin
         case (bus.address)
            REG_A:   a_nxt  = merge_bytes(reg_a, bus.writedata, bus.byteenable);
            REG_B:   b_nxt  = merge_bytes(reg_b, bus.writedata, bus.byteenable);
            REG_OP:  op_nxt = merge_bytes(reg_op, bus.writedata, bus.byteenable);
            default: ;
         endcase
      end
   end

   // Result built from next-state operands so it lands with the write
   always_ff @(posedge pr_region_clk) begin
      if (!rst_n) begin
         reg_a  <= '0;
         reg_b  <= '0;
         reg_op <= '0;
         result <= '0;
      end else begin
         reg_a  <= a_nxt;
         reg_b  <= b_nxt;
         reg_op <= op_nxt;
         result <= alu(a_nxt, b_nxt, arith_op_e'(op_nxt[1:0]));
      end
   end

   always_comb begin
      case (bus.address)
         REG_A:      rd_mux = reg_a;
         REG_B:      rd_mux = reg_b;
         REG_OP:     rd_mux = reg_op;
         REG_RESULT: rd_mux = result;
         REG_ID:     rd_mux = ARITH_ID;
         default:    rd_mux = '0;
      endcase
   end

   always_ff @(posedge pr_region_clk) begin
      if (!rst_n) begin
         bus.readdatavalid <= 1'b0;
      end else begin
         bus.readdatavalid <= bus.read;
      end
   end

   always_ff @(posedge pr_region_clk) begin
      if (bus.read) begin
         bus.readdata <= rd_mux;
      end
   end

   assign bus.waitrequest = 1'b0;

   // The mux forwards the host strobes unchanged
   a_rd_wr_exclusive: assert property (
      @(posedge pr_region_clk) disable iff (!rst_n)
      !(bus.read && bus.write)
   ) else $error("read and write high together at arith persona");

endmodule

//--- design/avmm_if.sv
// Avalon-MM register bus between the persona mux and one persona.
// The mux connects as host, the persona as agent.
`timescale 1ns/1ns

interface avmm_if;
   logic [pr_pkg::ADDR_W-1:0] address;
   logic [pr_pkg::DATA_W-1:0] writedata;
   logic [pr_pkg::BE_W-1:0]   byteenable;
   logic                      write;
   logic                      read;
   logic [pr_pkg::DATA_W-1:0] readdata;
   logic                      readdatavalid;
   logic                      waitrequest;

   modport host (
      output address, writedata, byteenable, write, read,
      input  readdata, readdatavalid, waitrequest
   );

   modport agent (
      input  address, writedata, byteenable, write, read,
      output readdata, readdatavalid, waitrequest
   );
endinterface

//--- design/dsp_persona.sv
// Multiply-accumulate persona.
// Each sample write adds coefficient times sample to a wrapping accumulator.
`timescale 1ns/1ns

module dsp_persona (
   input logic   pr_region_clk,
   input logic   rst_n,
   avmm_if.agent bus
);
   import pr_pkg::*;

   logic [DATA_W-1:0] coef;
   logic [DATA_W-1:0] acc;
   logic [DATA_W-1:0] product;
   logic [DATA_W-1:0] rd_mux;

   // Low word of the product only
   assign product = coef * bus.writedata;

   // Full-word writes, byte enables have no effect here
   always_ff @(posedge pr_region_clk) begin
      if (!rst_n) begin
         coef <= '0;
         acc  <= '0;
      end else if (bus.write) begin
         case (bus.address)
            REG_A: begin
               coef <= bus.writedata;
            end
            REG_B: begin
               acc <= acc + product;
            end
            REG_OP: begin
               acc <= '0;
            end
            default: ;
         endcase
      end
   end

   always_comb begin
      case (bus.address)
         REG_RESULT: rd_mux = acc;
         REG_ID:     rd_mux = DSP_ID;
         default:    rd_mux = '0;
      endcase
   end

   always_ff @(posedge pr_region_clk) begin
      if (!rst_n) begin
         bus.readdatavalid <= 1'b0;
      end else begin
         bus.readdatavalid <= bus.read;
      end
   end

   always_ff @(posedge pr_region_clk) begin
      if (bus.read) begin
         bus.readdata <= rd_mux;
      end
   end

   assign bus.waitrequest = 1'b0;

   a_rd_wr_exclusive: assert property (
      @(posedge pr_region_clk) disable iff (!rst_n)
      !(bus.read && bus.write)
   ) else $error("read and write high together at dsp persona");

endmodule

//--- design/persona_mux.sv
// Steers the region register port to the selected persona.
// Stalls every transfer while frozen or reconfiguring and blanks responses
// while pr_activate is high.
`timescale 1ns/1ns

module persona_mux (
   input  logic                      pr_region_clk,
   input  logic                      rst_n,
   input  logic                      pr_activate,
   input  logic                      freeze,
   input  logic [pr_pkg::SEL_W-1:0]  sel,
   input  logic [pr_pkg::ADDR_W-1:0] address,
   input  logic [pr_pkg::DATA_W-1:0] writedata,
   input  logic [pr_pkg::BE_W-1:0]   byteenable,
   input  logic                      write,
   input  logic                      read,
   output logic [pr_pkg::DATA_W-1:0] readdata,
   output logic                      readdatavalid,
   output logic                      waitrequest,
   avmm_if.host                      arith_bus,
   avmm_if.host                      dsp_bus
);
   import pr_pkg::*;

   logic                   hold;
   logic [NUM_PERSONA-1:0] hit;
   logic [NUM_PERSONA-1:0] rsp_valid;
   logic [NUM_PERSONA-1:0] rsp_wait;
   logic [DATA_W-1:0]      rsp_data [NUM_PERSONA];

   assign hold = freeze | pr_activate;

   // One-hot persona enable that stays empty while held
   always_comb begin
      for (int i = 0; i < NUM_PERSONA; i++) begin
         hit[i] = !hold && (sel == SEL_W'(i));
      end
   end

   assign arith_bus.address    = address;
   assign arith_bus.writedata  = writedata;
   assign arith_bus.byteenable = byteenable;
   assign arith_bus.write      = write & hit[PERSONA_ARITH];
   assign arith_bus.read       = read & hit[PERSONA_ARITH];

   assign dsp_bus.address      = address;
   assign dsp_bus.writedata    = writedata;
   assign dsp_bus.byteenable   = byteenable;
   assign dsp_bus.write        = write & hit[PERSONA_DSP];
   assign dsp_bus.read         = read & hit[PERSONA_DSP];

   assign rsp_valid[PERSONA_ARITH] = arith_bus.readdatavalid;
   assign rsp_wait[PERSONA_ARITH]  = arith_bus.waitrequest;
   assign rsp_data[PERSONA_ARITH]  = arith_bus.readdata;
   assign rsp_valid[PERSONA_DSP]   = dsp_bus.readdatavalid;
   assign rsp_wait[PERSONA_DSP]    = dsp_bus.waitrequest;
   assign rsp_data[PERSONA_DSP]    = dsp_bus.readdata;

   // Responses forced to zero during activation
   assign waitrequest   = hold | rsp_wait[sel];
   assign readdatavalid = !pr_activate & rsp_valid[sel];
   assign readdata      = pr_activate ? '0 : rsp_data[sel];

   a_sel_stable: assert property (
      @(posedge pr_region_clk) disable iff (!rst_n)
      (!pr_activate && !$past(pr_activate)) |-> $stable(sel)
   ) else $error("persona_sel changed outside pr_activate");

   // Only a read accepted just before activation can still answer
   a_no_valid_in_activate: assert property (
      @(posedge pr_region_clk) disable iff (!rst_n)
      (pr_activate && $past(pr_activate)) |-> (rsp_valid == '0)
   ) else $error("persona response seen after a full cycle of pr_activate");

endmodule

//--- design/pr_handshake_ctrl.sv
// Start/stop handshake for the PR region.
// Keeps the region frozen until a start completes and refreezes it on stop.
`timescale 1ns/1ns

module pr_handshake_ctrl (
   input  logic pr_region_clk,
   input  logic rst_n,
   input  logic start_req,
   input  logic stop_req,
   output logic start_ack,
   output logic stop_ack,
   output logic freeze
);
   import pr_pkg::*;

   hs_state_e state;

   always_ff @(posedge pr_region_clk) begin
      if (!rst_n) begin
         state     <= HS_FROZEN;
         start_ack <= 1'b0;
         stop_ack  <= 1'b0;
         freeze    <= 1'b1;
      end else begin
         case (state)
            HS_FROZEN: begin
               if (start_req) begin
                  state     <= HS_STARTING;
                  start_ack <= 1'b1;
                  freeze    <= 1'b0;
               end
            end
            HS_STARTING: begin
               // Ack held until the requester lets go
               if (!start_req) begin
                  state     <= HS_RUNNING;
                  start_ack <= 1'b0;
               end
            end
            HS_RUNNING: begin
               if (stop_req) begin
                  state  <= HS_STOPPING;
                  freeze <= 1'b1;
               end
            end
            HS_STOPPING: begin
               // Freeze goes up one cycle ahead of the ack
               if (!stop_ack) begin
                  stop_ack <= 1'b1;
               end else if (!stop_req) begin
                  stop_ack <= 1'b0;
                  state    <= HS_FROZEN;
               end
            end
            default: begin
               state <= HS_FROZEN;
            end
         endcase
      end
   end

   a_acks_exclusive: assert property (
      @(posedge pr_region_clk) disable iff (!rst_n)
      !(start_ack && stop_ack)
   ) else $error("start_ack and stop_ack high together");

endmodule

//--- design/pr_pkg.sv
// Shared widths, register map, persona codes and enums for the PR region.
// Imported by every module of the region and referenced by the bus interface.
package pr_pkg;

   // Bus widths
   localparam int ADDR_W      = 16;
   localparam int DATA_W      = 32;
   localparam int BE_W        = 4;

   // Resident personas and the select that picks one
   localparam int NUM_PERSONA = 2;
   localparam int SEL_W       = 1;

   localparam logic [SEL_W-1:0] PERSONA_ARITH = 1'b0;
   localparam logic [SEL_W-1:0] PERSONA_DSP   = 1'b1;

   // Values returned from the ID register of each persona
   localparam logic [DATA_W-1:0] ARITH_ID = 32'h4152_0001;
   localparam logic [DATA_W-1:0] DSP_ID   = 32'h4453_0002;

   // Register map, decoded by both personas
   localparam logic [ADDR_W-1:0] REG_A      = 16'd0;
   localparam logic [ADDR_W-1:0] REG_B      = 16'd1;
   localparam logic [ADDR_W-1:0] REG_OP     = 16'd2;
   localparam logic [ADDR_W-1:0] REG_RESULT = 16'd3;
   localparam logic [ADDR_W-1:0] REG_ID     = 16'd4;

   typedef enum logic [1:0] {
      OP_ADD,
      OP_SUB,
      OP_MUL,
      OP_AND
   } arith_op_e;

   typedef enum logic [1:0] {
      HS_FROZEN,
      HS_STARTING,
      HS_RUNNING,
      HS_STOPPING
   } hs_state_e;

endpackage

//--- design/pr_region_top.sv
// Top level of the PR region with both personas resident.
// Plain Avalon-MM and handshake ports, persona picked by persona_sel.
`timescale 1ns/1ns

module pr_region_top (
   input  logic                      pr_region_clk,
   input  logic                      rst_n,
   input  logic                      pr_activate,
   input  logic [pr_pkg::SEL_W-1:0]  persona_sel,
   input  logic                      pr_handshake_start_req,
   input  logic                      pr_handshake_stop_req,
   input  logic [pr_pkg::ADDR_W-1:0] avmm_address,
   input  logic [pr_pkg::DATA_W-1:0] avmm_writedata,
   input  logic [pr_pkg::BE_W-1:0]   avmm_byteenable,
   input  logic                      avmm_write,
   input  logic                      avmm_read,
   output logic                      pr_handshake_start_ack,
   output logic                      pr_handshake_stop_ack,
   output logic                      freeze_pr_region_avmm,
   output logic [pr_pkg::DATA_W-1:0] avmm_readdata,
   output logic                      avmm_readdatavalid,
   output logic                      avmm_waitrequest
);

   avmm_if arith_if ();
   avmm_if dsp_if ();

   pr_handshake_ctrl u_pr_handshake_ctrl (
      .pr_region_clk (pr_region_clk),
      .rst_n         (rst_n),
      .start_req     (pr_handshake_start_req),
      .stop_req      (pr_handshake_stop_req),
      .start_ack     (pr_handshake_start_ack),
      .stop_ack      (pr_handshake_stop_ack),
      .freeze        (freeze_pr_region_avmm)
   );

   persona_mux u_persona_mux (
      .pr_region_clk (pr_region_clk),
      .rst_n         (rst_n),
      .pr_activate   (pr_activate),
      .freeze        (freeze_pr_region_avmm),
      .sel           (persona_sel),
      .address       (avmm_address),
      .writedata     (avmm_writedata),
      .byteenable    (avmm_byteenable),
      .write         (avmm_write),
      .read          (avmm_read),
      .readdata      (avmm_readdata),
      .readdatavalid (avmm_readdatavalid),
      .waitrequest   (avmm_waitrequest),
      .arith_bus     (arith_if),
      .dsp_bus       (dsp_if)
   );

   arith_persona u_arith_persona (
      .pr_region_clk (pr_region_clk),
      .rst_n         (rst_n),
      .bus           (arith_if)
   );

   dsp_persona u_dsp_persona (
      .pr_region_clk (pr_region_clk),
      .rst_n         (rst_n),
      .bus           (dsp_if)
   );

endmodule

//--- sim.f
design/pr_pkg.sv
design/avmm_if.sv
design/pr_handshake_ctrl.sv
design/persona_mux.sv
design/arith_persona.sv
design/dsp_persona.sv
design/pr_region_top.sv
verification/tb_pr_region.sv

//--- verification/tb_pr_region.sv
// Testbench for the PR region top level.
// Runs both handshakes, the two personas, a reconfiguration and back-to-back
// reads, and checks every read response against a register model.
`timescale 1ns/1ns

module tb_pr_region;
   import pr_pkg::*;

   localparam logic WR        = 1'b1;
   localparam logic RD        = 1'b0;
   localparam int N_ARITH     = 12;
   localparam int N_DSP       = 10;
   // Rough length of the whole sequence in clock cycles
   localparam int TEST_CYCLES = 100 + 5 * N_ARITH + 3 * N_DSP;
   localparam int TIMEOUT     = 3 * TEST_CYCLES;

   logic              pr_region_clk = 1'b0;
   logic              rst_n;
   logic              pr_activate;
   logic [SEL_W-1:0]  persona_sel;
   logic              start_req;
   logic              stop_req;
   logic [ADDR_W-1:0] avmm_address;
   logic [DATA_W-1:0] avmm_writedata;
   logic [BE_W-1:0]   avmm_byteenable;
   logic              avmm_write;
   logic              avmm_read;
   logic              start_ack;
   logic              stop_ack;
   logic              freeze;
   logic [DATA_W-1:0] avmm_readdata;
   logic              avmm_readdatavalid;
   logic              avmm_waitrequest;

   logic [31:0]       lfsr = 32'hc6d9;
   int                cycles = 0;
   int                data_errors = 0;
   int                proto_errors = 0;
   // Register model of both personas
   logic [DATA_W-1:0] m_a = '0;
   logic [DATA_W-1:0] m_b = '0;
   logic [DATA_W-1:0] m_op = '0;
   logic [DATA_W-1:0] m_coef = '0;
   logic [DATA_W-1:0] m_acc = '0;
   // Expected read data and the cycle each read was accepted in
   logic [DATA_W-1:0] exp_q [$];
   int                tag_q [$];

   pr_region_top u_pr_region_top (
      .pr_region_clk          (pr_region_clk),
      .rst_n                  (rst_n),
      .pr_activate            (pr_activate),
      .persona_sel            (persona_sel),
      .pr_handshake_start_req (start_req),
      .pr_handshake_stop_req  (stop_req),
      .avmm_address           (avmm_address),
      .avmm_writedata         (avmm_writedata),
      .avmm_byteenable        (avmm_byteenable),
      .avmm_write             (avmm_write),
      .avmm_read              (avmm_read),
      .pr_handshake_start_ack (start_ack),
      .pr_handshake_stop_ack  (stop_ack),
      .freeze_pr_region_avmm  (freeze),
      .avmm_readdata          (avmm_readdata),
      .avmm_readdatavalid     (avmm_readdatavalid),
      .avmm_waitrequest       (avmm_waitrequest)
   );

   always #5 pr_region_clk = ~pr_region_clk;

   always @(posedge pr_region_clk) begin
      if (cycles >= TIMEOUT) begin
         $display("Timeout: tests still running after %0d cycles", cycles);
         $display("Simulation failed");
         $finish;
      end else begin
         cycles <= cycles + 1;
      end
   end

   // Taps for x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   // One LFSR step per bit taken
   function automatic logic [31:0] take_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr_step(lfsr);
         v    = {v[30:0], lfsr[0]};
      end
      return v;
   endfunction

   function automatic logic [DATA_W-1:0] apply_lanes(input logic [DATA_W-1:0] old_word,
         input logic [DATA_W-1:0] new_word, input logic [BE_W-1:0] be);
      logic [DATA_W-1:0] w;
      w = old_word;
      for (int i = 0; i < BE_W; i++) begin
         if (be[i]) begin
            w[8*i +: 8] = new_word[8*i +: 8];
         end
      end
      return w;
   endfunction

   // Reference value of a read from the model state
   function automatic logic [DATA_W-1:0] expected_read(input logic [SEL_W-1:0] sel,
                                                       input logic [ADDR_W-1:0] addr);
      logic [DATA_W-1:0] r;
      r = '0;
      if (sel == PERSONA_ARITH) begin
         case (addr)
            REG_A:      r = m_a;
            REG_B:      r = m_b;
            REG_OP:     r = m_op;
            REG_RESULT: begin
               case (arith_op_e'(m_op[1:0]))
                  OP_ADD: r = m_a + m_b;
                  OP_SUB: r = m_a - m_b;
                  OP_MUL: r = m_a * m_b;
                  OP_AND: r = m_a & m_b;
               endcase
            end
            REG_ID:     r = ARITH_ID;
            default:    r = '0;
         endcase
      end else begin
         case (addr)
            REG_RESULT: r = m_acc;
            REG_ID:     r = DSP_ID;
            default:    r = '0;
         endcase
      end
      return r;
   endfunction

   task automatic model_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                              input logic [BE_W-1:0] be);
      if (persona_sel == PERSONA_ARITH) begin
         case (addr)
            REG_A:   m_a  = apply_lanes(m_a, data, be);
            REG_B:   m_b  = apply_lanes(m_b, data, be);
            REG_OP:  m_op = apply_lanes(m_op, data, be);
            default: ;
         endcase
      end else begin
         // DSP writes take the whole word
         case (addr)
            REG_A:   m_coef = data;
            REG_B:   m_acc  = m_acc + m_coef * data;
            REG_OP:  m_acc  = '0;
            default: ;
         endcase
      end
   endtask

   task automatic check_bit(input string what, input logic actual, input logic expected);
      assert (actual === expected) else begin
         data_errors++;
         $display("Fail %0t: %s is %b, expected %b", $time, what, actual, expected);
      end
   endtask

   // Drives one transfer and returns after the edge that accepts it
   task automatic transfer(input logic is_write, input logic [ADDR_W-1:0] addr,
                           input logic [DATA_W-1:0] data, input logic [BE_W-1:0] be);
      @(negedge pr_region_clk);
      avmm_address    = addr;
      avmm_writedata  = data;
      avmm_byteenable = be;
      avmm_write      = is_write;
      avmm_read       = !is_write;
      #1;
      while (avmm_waitrequest) begin
         @(negedge pr_region_clk);
         #1;
      end
      if (is_write) begin
         model_write(addr, data, be);
      end else begin
         exp_q.push_back(expected_read(persona_sel, addr));
         tag_q.push_back(cycles);
      end
      @(posedge pr_region_clk);
   endtask

   task automatic go_idle();
      @(negedge pr_region_clk);
      avmm_write = 1'b0;
      avmm_read  = 1'b0;
   endtask

   task automatic drain();
      while (exp_q.size() != 0) begin
         @(negedge pr_region_clk);
      end
   endtask

   task automatic start_handshake();
      @(negedge pr_region_clk);
      start_req = 1'b1;
      @(negedge pr_region_clk);
      check_bit("start_ack one cycle after start_req", start_ack, 1'b1);
      check_bit("freeze with start_ack", freeze, 1'b0);
      repeat (3) begin
         @(negedge pr_region_clk);
         check_bit("start_ack held", start_ack, 1'b1);
      end
      start_req = 1'b0;
      @(negedge pr_region_clk);
      check_bit("start_ack after start_req drop", start_ack, 1'b0);
      check_bit("waitrequest when running", avmm_waitrequest, 1'b0);
   endtask

   // Response checker, one cycle read latency
   always @(negedge pr_region_clk) begin
      if (rst_n && avmm_readdatavalid) begin
         assert (exp_q.size() > 0) else begin
            proto_errors++;
            $display("readdatavalid at %0t with no read outstanding", $time);
         end
         if (exp_q.size() > 0) begin
            assert (tag_q[0] + 1 == cycles) else begin
               proto_errors++;
               $display("Read response at %0t came %0d cycles after its read",
                        $time, cycles - tag_q[0]);
            end
            assert (avmm_readdata === exp_q[0]) else begin
               data_errors++;
               $display("Fail %0t: readdata %h, expected %h", $time, avmm_readdata, exp_q[0]);
            end
            void'(exp_q.pop_front());
            void'(tag_q.pop_front());
         end
      end else if (rst_n && exp_q.size() > 0) begin
         assert (tag_q[0] + 1 > cycles) else begin
            proto_errors++;
            $display("No read response at %0t for the read of cycle %0d", $time, tag_q[0]);
         end
         if (tag_q[0] + 1 <= cycles) begin
            void'(exp_q.pop_front());
            void'(tag_q.pop_front());
         end
      end
   end

   initial begin
      logic [31:0] lanes;
      rst_n           = 1'b0;
      pr_activate     = 1'b0;
      persona_sel     = PERSONA_ARITH;
      start_req       = 1'b0;
      stop_req        = 1'b0;
      avmm_address    = '0;
      avmm_writedata  = '0;
      avmm_byteenable = '0;
      avmm_write      = 1'b0;
      avmm_read       = 1'b0;
      repeat (16) @(negedge pr_region_clk);
      rst_n = 1'b1;

      // Region comes out of reset frozen
      @(negedge pr_region_clk);
      check_bit("freeze after reset", freeze, 1'b1);
      check_bit("start_ack after reset", start_ack, 1'b0);
      check_bit("stop_ack after reset", stop_ack, 1'b0);
      check_bit("waitrequest after reset", avmm_waitrequest, 1'b1);
      check_bit("readdatavalid after reset", avmm_readdatavalid, 1'b0);
      start_handshake();

      // Arithmetic persona, partial byte enables on operand writes
      transfer(RD, REG_ID, '0, '0);
      for (int i = 0; i < N_ARITH; i++) begin
         lanes = take_bits(4);
         transfer(WR, REG_A, take_bits(32), (i % 2 == 0) ? lanes[3:0] : 4'hf);
         lanes = take_bits(4);
         transfer(WR, REG_B, take_bits(32), lanes[3:0]);
         transfer(WR, REG_OP, take_bits(32), 4'hf);
         transfer(RD, REG_RESULT, '0, '0);
         transfer(RD, REG_A, '0, '0);
      end
      go_idle();

      // Reconfiguration to the DSP persona with a read held pending
      drain();
      @(negedge pr_region_clk);
      pr_activate  = 1'b1;
      avmm_read    = 1'b1;
      avmm_address = REG_ID;
      @(negedge pr_region_clk);
      persona_sel = PERSONA_DSP;
      repeat (5) begin
         @(negedge pr_region_clk);
         check_bit("readdata blank during activate", |avmm_readdata, 1'b0);
         check_bit("readdatavalid during activate", avmm_readdatavalid, 1'b0);
         check_bit("waitrequest during activate", avmm_waitrequest, 1'b1);
      end
      pr_activate = 1'b0;
      avmm_read   = 1'b0;
      transfer(RD, REG_ID, '0, '0);

      // Multiply-accumulate, byte enables ignored
      transfer(WR, REG_A, take_bits(32), 4'hf);
      for (int i = 0; i < N_DSP; i++) begin
         lanes = take_bits(4);
         transfer(WR, REG_B, take_bits(32), lanes[3:0]);
         transfer(RD, REG_RESULT, '0, '0);
      end
      transfer(WR, REG_OP, '0, 4'h1);
      transfer(RD, REG_RESULT, '0, '0);
      // Fresh accumulation that must survive the stop
      transfer(WR, REG_A, take_bits(32), 4'hf);
      transfer(WR, REG_B, take_bits(32), 4'hf);
      transfer(WR, REG_B, take_bits(32), 4'hf);
      go_idle();

      // Stop handshake, then a write attempted while frozen
      drain();
      @(negedge pr_region_clk);
      stop_req = 1'b1;
      @(negedge pr_region_clk);
      check_bit("freeze one cycle after stop_req", freeze, 1'b1);
      check_bit("stop_ack before its cycle", stop_ack, 1'b0);
      @(negedge pr_region_clk);
      check_bit("stop_ack two cycles after stop_req", stop_ack, 1'b1);
      avmm_address    = REG_B;
      avmm_writedata  = take_bits(32);
      avmm_byteenable = 4'hf;
      avmm_write      = 1'b1;
      repeat (4) begin
         check_bit("waitrequest while frozen", avmm_waitrequest, 1'b1);
         check_bit("stop_ack held", stop_ack, 1'b1);
         @(negedge pr_region_clk);
      end
      avmm_write = 1'b0;
      stop_req   = 1'b0;
      @(negedge pr_region_clk);
      check_bit("stop_ack after stop_req drop", stop_ack, 1'b0);
      check_bit("freeze after stop", freeze, 1'b1);
      start_handshake();

      // Readback after restart as reads on consecutive cycles
      transfer(RD, REG_RESULT, '0, '0);
      transfer(RD, REG_ID, '0, '0);
      transfer(RD, REG_A, '0, '0);
      transfer(RD, 16'h0007, '0, '0);
      transfer(RD, REG_RESULT, '0, '0);
      go_idle();
      drain();
      repeat (2) @(negedge pr_region_clk);

      $display("Errors: %0d data, %0d protocol", data_errors, proto_errors);
      if (data_errors + proto_errors == 0) begin
         $display("Simulation completed successfully");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule
